//--- hdl/tstamp_pkg.sv
`default_nettype none

package tstamp_pkg;

    // ************************************************************
    // Sizes
    // ************************************************************
    localparam int ts_width       = 64;
    localparam int word_width     = 32;
    localparam int bus_add_width  = 16;
    localparam int bus_data_width = 8;

    localparam int event_depth = 16;  // Event queue entries
    localparam int word_depth  = 64;  // Output FIFO entries

    // ************************************************************
    // Register map and identification
    // ************************************************************
    localparam logic [bus_data_width-1:0] version = 8'd0;

    localparam logic [bus_add_width-1:0] reg_reset_add  = 16'd0;
    localparam logic [bus_add_width-1:0] reg_enable_add = 16'd2;
    localparam logic [bus_add_width-1:0] reg_lost_add   = 16'd3;

    // Every output word starts with the identifier nibble, then a frame tag
    localparam logic [3:0] ident    = 4'd1;
    localparam logic [3:0] tag_low  = 4'd1;
    localparam logic [3:0] tag_mid  = 4'd2;
    localparam logic [3:0] tag_high = 4'd3;

    // ************************************************************
    // Payload types
    // ************************************************************
    typedef logic [ts_width-1:0]   ts_t;
    typedef logic [word_width-1:0] word_t;

endpackage

`default_nettype wire

//--- hdl/tstamp_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tstamp_fifo import tstamp_pkg::*; #(
    parameter type payload_t = word_t
) (
    input  wire           BUS_CLK,
    input  wire           RST_SYNC,
    input  wire           clr,
    input  wire           push,
    input  wire payload_t din,
    input  wire           pop,
    output payload_t      dout,
    output logic          full,
    output logic          empty
);

    // Events get the short queue, formatted words the deep one
    localparam int depth     = ($bits(payload_t) == ts_width) ? event_depth : word_depth;
    localparam int ptr_width = $clog2(depth);

    localparam logic [ptr_width:0] count_max = (ptr_width + 1)'(depth);

    payload_t             mem [depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0]   count;
    logic                 do_push;
    logic                 do_pop;

    assign full  = (count == count_max);
    assign empty = (count == '0);

    assign do_push = push && !full;   // Push into a full buffer is lost
    assign do_pop  = pop && !empty;

    // First word fall through, head entry always visible
    assign dout = mem[rd_ptr];

    always_ff @(posedge BUS_CLK) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // ************************************************************
    // Pointers and fill level
    // ************************************************************
    always_ff @(posedge BUS_CLK) begin
        if (RST_SYNC || clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, pointer wraps
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/tstamp_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tstamp_reg_decode import tstamp_pkg::*; (
    input  wire                            BUS_CLK,
    input  wire                            RST_SYNC,
    input  wire [bus_add_width-1:0]        bus_add,
    input  wire [bus_data_width-1:0]       bus_data_in,
    input  wire                            bus_wr,
    input  wire                            bus_rd,
    input  wire [bus_data_width-1:0]       lost_cnt,
    output logic [bus_data_width-1:0]      bus_data_out,
    output logic                           enable,
    output logic                           soft_rst
);

    logic                      wr_reset;
    logic                      wr_enable;
    logic [bus_data_width-1:0] rd_mux;

    // ************************************************************
    // Write decode
    // ************************************************************
    assign wr_reset  = bus_wr && (bus_add == reg_reset_add);
    assign wr_enable = bus_wr && (bus_add == reg_enable_add);

    // Any value written to the reset address gives one pulse
    always_ff @(posedge BUS_CLK) begin
        if (RST_SYNC) begin
            soft_rst <= 1'b0;
        end else begin
            soft_rst <= wr_reset;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST_SYNC || soft_rst) begin
            enable <= 1'b0;
        end else if (wr_enable) begin
            enable <= bus_data_in[0];  // Only bit 0 is implemented
        end
    end

    // ************************************************************
    // Read path
    // ************************************************************
    always_comb begin
        case (bus_add)
            reg_reset_add: begin
                rd_mux = version;
            end
            reg_enable_add: begin
                rd_mux = {{(bus_data_width - 1){1'b0}}, enable};
            end
            reg_lost_add: begin
                rd_mux = lost_cnt;
            end
            default: begin
                rd_mux = '0;  // Unmapped addresses
            end
        endcase
    end

    // Read data appears the cycle after the strobe and then holds
    always_ff @(posedge BUS_CLK) begin
        if (RST_SYNC) begin
            bus_data_out <= '0;
        end else if (bus_rd) begin
            bus_data_out <= rd_mux;
        end
    end

endmodule

`default_nettype wire

//--- hdl/tstamp_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tstamp_capture import tstamp_pkg::*; (
    input  wire                       BUS_CLK,
    input  wire                       RST_SYNC,
    input  wire                       soft_rst,
    input  wire                       enable,
    input  wire                       di,
    input  wire                       ev_full,
    output logic                      ev_push,
    output ts_t                       ev_data,
    output ts_t                       timestamp,
    output logic [bus_data_width-1:0] lost_cnt
);

    logic di_meta;
    logic di_sync;
    logic di_last;
    logic hit_rise;
    ts_t  counter;
    ts_t  stamp_q;

    // ************************************************************
    // Hit synchronizer and edge detect
    // ************************************************************
    always_ff @(posedge BUS_CLK) begin
        if (RST_SYNC) begin
            di_meta <= 1'b0;
            di_sync <= 1'b0;
            di_last <= 1'b0;
        end else begin
            di_meta <= di;       // First stage may go metastable
            di_sync <= di_meta;
            di_last <= di_sync;
        end
    end

    assign hit_rise = di_sync && !di_last;

    // Free-running time base
    always_ff @(posedge BUS_CLK) begin
        if (RST_SYNC || soft_rst) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    // ************************************************************
    // Event capture
    // ************************************************************
    always_ff @(posedge BUS_CLK) begin
        if (RST_SYNC || soft_rst) begin
            ev_push <= 1'b0;
        end else begin
            ev_push <= hit_rise && enable;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (hit_rise && enable) begin
            stamp_q <= counter;
        end
    end

    assign ev_data   = stamp_q;
    assign timestamp = stamp_q;  // Stays on the last captured event

    // A push into a full queue is dropped, count it and stop at 255
    always_ff @(posedge BUS_CLK) begin
        if (RST_SYNC || soft_rst) begin
            lost_cnt <= '0;
        end else if (ev_push && ev_full && (lost_cnt != '1)) begin
            lost_cnt <= lost_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/tstamp_word_format.sv
`timescale 1ns/1ps
`default_nettype none

module tstamp_word_format import tstamp_pkg::*; (
    input  wire        BUS_CLK,
    input  wire        RST_SYNC,
    input  wire        soft_rst,
    input  wire        ev_empty,
    input  wire ts_t   ev_data,
    output logic       ev_pop,
    input  wire        wd_full,
    output logic       wd_push,
    output word_t      wd_data
);

    logic [1:0] phase;    // 0 idle, 1..3 word being emitted
    ts_t        ev_buf;
    logic       advance;

    // ************************************************************
    // Phase control
    // ************************************************************
    assign advance = (phase != 2'd0) && !wd_full;

    // The next event is fetched while the last word goes out,
    // so back to back events cost three cycles each
    assign ev_pop = !ev_empty && ((phase == 2'd0) || ((phase == 2'd3) && !wd_full));

    always_ff @(posedge BUS_CLK) begin
        if (RST_SYNC || soft_rst) begin
            phase <= 2'd0;
        end else if (ev_pop) begin
            phase <= 2'd1;
        end else if (advance) begin
            phase <= phase + 2'd1;  // Phase 3 wraps to idle
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (ev_pop) begin
            ev_buf <= ev_data;
        end
    end

    // ************************************************************
    // Word assembly
    // ************************************************************
    assign wd_push = advance;  // Word is held while the output FIFO is full

    always_comb begin
        case (phase)
            2'd1: begin
                wd_data = {ident, tag_low, ev_buf[23:0]};
            end
            2'd2: begin
                wd_data = {ident, tag_mid, ev_buf[47:24]};
            end
            2'd3: begin
                wd_data = {ident, tag_high, 8'h00, ev_buf[63:48]};
            end
            default: begin
                wd_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/tstamp_top.sv
`timescale 1ns/1ps
`default_nettype none

module tstamp_top import tstamp_pkg::*; (
    input  wire                       BUS_CLK,
    input  wire                       RST_SYNC,
    input  wire                       di,
    input  wire [bus_add_width-1:0]   bus_add,
    input  wire [bus_data_width-1:0]  bus_data_in,
    input  wire                       bus_wr,
    input  wire                       bus_rd,
    output wire [bus_data_width-1:0]  bus_data_out,
    input  wire                       fifo_read,
    output wire                       fifo_empty,
    output word_t                     fifo_data,
    output ts_t                       timestamp
);

    wire                      enable;
    wire                      soft_rst;
    wire [bus_data_width-1:0] lost_cnt;

    wire ev_push;
    wire ev_pop;
    wire ev_full;
    wire ev_empty;
    ts_t ev_data;   // Capture into the event queue
    ts_t ev_head;   // Event queue into the formatter

    wire   wd_push;
    wire   wd_full;
    word_t wd_data;

    // ************************************************************
    // Register bus
    // ************************************************************
    tstamp_reg_decode i_reg_decode (
        .BUS_CLK      (BUS_CLK),
        .RST_SYNC     (RST_SYNC),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .lost_cnt     (lost_cnt),
        .bus_data_out (bus_data_out),
        .enable       (enable),
        .soft_rst     (soft_rst)
    );

    // ************************************************************
    // Capture path
    // ************************************************************
    tstamp_capture i_capture (
        .BUS_CLK   (BUS_CLK),
        .RST_SYNC  (RST_SYNC),
        .soft_rst  (soft_rst),
        .enable    (enable),
        .di        (di),
        .ev_full   (ev_full),
        .ev_push   (ev_push),
        .ev_data   (ev_data),
        .timestamp (timestamp),
        .lost_cnt  (lost_cnt)
    );

    tstamp_fifo #(.payload_t(ts_t)) i_event_fifo (
        .BUS_CLK  (BUS_CLK),
        .RST_SYNC (RST_SYNC),
        .clr      (soft_rst),
        .push     (ev_push),
        .din      (ev_data),
        .pop      (ev_pop),
        .dout     (ev_head),
        .full     (ev_full),
        .empty    (ev_empty)
    );

    // ************************************************************
    // Readout path
    // ************************************************************
    tstamp_word_format i_word_format (
        .BUS_CLK  (BUS_CLK),
        .RST_SYNC (RST_SYNC),
        .soft_rst (soft_rst),
        .ev_empty (ev_empty),
        .ev_data  (ev_head),
        .ev_pop   (ev_pop),
        .wd_full  (wd_full),
        .wd_push  (wd_push),
        .wd_data  (wd_data)
    );

    tstamp_fifo #(.payload_t(word_t)) i_word_fifo (
        .BUS_CLK  (BUS_CLK),
        .RST_SYNC (RST_SYNC),
        .clr      (soft_rst),
        .push     (wd_push),
        .din      (wd_data),
        .pop      (fifo_read),
        .dout     (fifo_data),
        .full     (wd_full),
        .empty    (fifo_empty)
    );

endmodule

`default_nettype wire

//--- verification/tstamp_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module tstamp_asserts import tstamp_pkg::*; (
    input wire        BUS_CLK,
    input wire        RST_SYNC,
    input wire        soft_rst,
    input wire        ev_pop,
    input wire        ev_empty,
    input wire        wd_push,
    input wire        wd_full,
    input wire word_t wd_data,
    input wire        fifo_empty
);

    int         fail_cnt = 0;
    logic [3:0] last_tag;   // Tag of the previous formatted word
    logic [3:0] next_tag;

    always_ff @(posedge BUS_CLK) begin
        if (RST_SYNC || soft_rst) begin
            last_tag <= 4'd3;   // Next frame starts with the low word
        end else if (wd_push) begin
            last_tag <= wd_data[27:24];
        end
    end

    assign next_tag = (last_tag == 4'd3) ? 4'd1 : last_tag + 4'd1;

    // ************************************************************
    // Handshake and ordering rules
    // ************************************************************
    no_push_when_full: assert property (@(posedge BUS_CLK) disable iff (RST_SYNC)
        !(wd_push && wd_full))
    else begin
        fail_cnt++;
        $error("Formatter pushed a word into a full output FIFO");
    end

    no_pop_when_empty: assert property (@(posedge BUS_CLK) disable iff (RST_SYNC)
        !(ev_pop && ev_empty))
    else begin
        fail_cnt++;
        $error("Formatter popped an empty event queue");
    end

    empty_after_soft_rst: assert property (@(posedge BUS_CLK) disable iff (RST_SYNC)
        soft_rst |=> fifo_empty)
    else begin
        fail_cnt++;
        $error("Output FIFO not empty after soft reset");
    end

    tags_in_order: assert property (@(posedge BUS_CLK) disable iff (RST_SYNC || soft_rst)
        wd_push |-> (wd_data[27:24] == next_tag))
    else begin
        fail_cnt++;
        $error("Word tag out of order");
    end

endmodule

bind tstamp_top tstamp_asserts u_asserts (
    .BUS_CLK    (BUS_CLK),
    .RST_SYNC   (RST_SYNC),
    .soft_rst   (soft_rst),
    .ev_pop     (ev_pop),
    .ev_empty   (ev_empty),
    .wd_push    (wd_push),
    .wd_full    (wd_full),
    .wd_data    (wd_data),
    .fifo_empty (fifo_empty)
);

`default_nettype wire

//--- verification/tstamp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tstamp_tb import tstamp_pkg::*; ();

    typedef enum logic [2:0] {
        op_wr, op_rd, op_hit, op_empty, op_drain_gaps, op_drain_loss, op_stamp
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [15:0] addr;
        logic [7:0]  data;   // Write data, expected read, hit gap (0 is random) or stamp limit
        logic [7:0]  count;  // Number of hits
    } row_t;

    localparam int n_rows       = 22;
    localparam int drain_cycles = 300;

    row_t rows [n_rows] = '{
        '{op_rd, 16'd0, 8'd0, 8'd0},            // Version
        '{op_wr, 16'd2, 8'd1, 8'd0},
        '{op_rd, 16'd2, 8'd1, 8'd0},
        '{op_rd, 16'h0102, 8'd0, 8'd0},         // Unmapped, low byte matches the enable address
        '{op_wr, 16'd2, 8'd0, 8'd0},
        '{op_rd, 16'd2, 8'd0, 8'd0},
        '{op_hit, 16'd0, 8'd6, 8'd3},           // Hits while disabled
        '{op_empty, 16'd0, 8'd0, 8'd0},
        '{op_wr, 16'd2, 8'd1, 8'd0},
        '{op_hit, 16'd0, 8'd0, 8'd12},
        '{op_drain_gaps, 16'd0, 8'd0, 8'd0},
        '{op_hit, 16'd0, 8'd6, 8'd50},          // 8 cycles apart, no readout
        '{op_drain_loss, 16'd0, 8'd0, 8'd0},
        '{op_hit, 16'd0, 8'd6, 8'd2},           // Words are waiting when the soft reset hits
        '{op_wr, 16'd0, 8'd0, 8'd0},            // Soft reset
        '{op_empty, 16'd0, 8'd0, 8'd0},
        '{op_rd, 16'd3, 8'd0, 8'd0},
        '{op_rd, 16'd2, 8'd0, 8'd0},
        '{op_wr, 16'd2, 8'd1, 8'd0},
        '{op_hit, 16'd0, 8'd20, 8'd1},
        '{op_drain_gaps, 16'd0, 8'd0, 8'd0},
        '{op_stamp, 16'd0, 8'd100, 8'd0}
    };

    logic        BUS_CLK;
    logic        RST_SYNC;
    logic        di;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_wr;
    logic        bus_rd;
    logic        fifo_read;
    wire  [7:0]  bus_data_out;
    wire         fifo_empty;
    word_t       fifo_data;
    ts_t         timestamp;

    int     errors = 0;
    int     cycle_cnt = 0;
    int     cycle_limit = 0;
    integer seed = 74836;
    int     hit_cycles [$];   // Cycle at which each hit was driven
    ts_t    events [$];
    ts_t    cur_event;
    ts_t    last_event;
    int     word_idx;

    tstamp_top DUT (
        .BUS_CLK      (BUS_CLK),
        .RST_SYNC     (RST_SYNC),
        .di           (di),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .fifo_read    (fifo_read),
        .fifo_empty   (fifo_empty),
        .fifo_data    (fifo_data),
        .timestamp    (timestamp)
    );

    always #20 BUS_CLK = ~BUS_CLK;

    always @(posedge BUS_CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    function automatic int run_limit();
        int total;
        total = 5;
        foreach (rows[r]) begin
            case (rows[r].op)
                op_hit:                       total += rows[r].count *
                                                  (((rows[r].data == 0) ? 18 : rows[r].data) + 2);
                op_drain_gaps, op_drain_loss: total += drain_cycles;
                default:                      total += 20;
            endcase
        end
        return 2 * total;
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string msg);
        if (actual !== expected) begin
            errors++;
            $display("** Error @ %0t ns: %s (got %0h, expected %0h)", $time, msg, actual,
                     expected);
        end
    endtask

    // ************************************************************
    // Bus and hit drivers, all on the falling edge
    // ************************************************************
    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(negedge BUS_CLK);
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        bus_add = addr;
        bus_rd  = 1'b1;
        @(negedge BUS_CLK);
        bus_rd = 1'b0;
        data   = bus_data_out;   // Loaded at the edge in between
    endtask

    task automatic drive_hits(input int count, input int gap);
        int g;
        for (int i = 0; i < count; i++) begin
            g = (gap == 0) ? 3 + ($unsigned($random(seed)) % 16) : gap;
            repeat (g) @(negedge BUS_CLK);
            di = 1'b1;
            hit_cycles.push_back(cycle_cnt);
            repeat (2) @(negedge BUS_CLK);
            di = 1'b0;
        end
    endtask

    // ************************************************************
    // Readout model
    // ************************************************************
    task automatic collect_word(input word_t w);
        check(w[31:28], 4'd1, "ident nibble");
        check(w[27:24], word_idx + 1, "frame tag");
        case (word_idx)
            0: cur_event[23:0] = w[23:0];
            1: cur_event[47:24] = w[23:0];
            default: begin
                check(w[23:16], 8'h00, "pad bits of the high word");
                cur_event[63:48] = w[15:0];
                events.push_back(cur_event);
            end
        endcase
        word_idx = (word_idx + 1) % 3;
    endtask

    task automatic drain_output();
        int idle;
        idle = 0;
        word_idx = 0;
        events.delete();
        while (idle < 16) begin   // Stop once the output stays empty
            if (!fifo_empty) begin
                collect_word(fifo_data);
                fifo_read = 1'b1;
                idle = 0;
            end else begin
                fifo_read = 1'b0;
                idle++;
            end
            @(negedge BUS_CLK);
        end
        fifo_read = 1'b0;
        check(word_idx, 0, "whole frames of three words");
    endtask

    task automatic check_gaps();
        check(events.size(), hit_cycles.size(), "number of events");
        for (int i = 1; i < events.size() && i < hit_cycles.size(); i++) begin
            check(events[i] - events[i-1], hit_cycles[i] - hit_cycles[i-1], "timestamp delta");
        end
        if (events.size() > 0) begin
            last_event = events[events.size() - 1];
            check(timestamp, last_event, "timestamp port holds the last event");
        end
        hit_cycles.delete();
    endtask

    task automatic check_loss();
        logic [7:0] lost;
        bus_read(16'd3, lost);
        check(lost + events.size(), hit_cycles.size(), "lost count plus events read");
        check(lost > 0, 1'b1, "some events lost");
        hit_cycles.delete();
    endtask

    task automatic run_row(input row_t row);
        logic [7:0] rd;
        case (row.op)
            op_wr: bus_write(row.addr, row.data);
            op_rd: begin
                bus_read(row.addr, rd);
                check(rd, row.data, $sformatf("read of address %0h", row.addr));
            end
            op_hit: drive_hits(row.count, row.data);
            op_empty: begin
                repeat (16) begin
                    @(negedge BUS_CLK);
                    check(fifo_empty, 1'b1, "fifo_empty with no enabled hits");
                end
                hit_cycles.delete();
            end
            op_drain_gaps: begin
                drain_output();
                check_gaps();
            end
            op_drain_loss: begin
                drain_output();
                check_loss();
            end
            default: check(last_event < row.data, 1'b1, "timestamp after soft reset");
        endcase
    endtask

    initial begin
        BUS_CLK     = 1'b0;
        RST_SYNC    = 1'b1;
        di          = 1'b0;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        fifo_read   = 1'b0;
        word_idx    = 0;
        last_event  = '0;
        cycle_limit = run_limit();
        repeat (5) @(negedge BUS_CLK);
        RST_SYNC = 1'b0;
        @(negedge BUS_CLK);
        foreach (rows[r]) begin
            run_row(rows[r]);
        end
        $display("Mismatches: %0d, assertion failures: %0d", errors, DUT.u_asserts.fail_cnt);
        if (errors == 0 && DUT.u_asserts.fail_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hdl/tstamp_pkg.sv
hdl/tstamp_fifo.sv
hdl/tstamp_reg_decode.sv
hdl/tstamp_capture.sv
hdl/tstamp_word_format.sv
hdl/tstamp_top.sv
verification/tstamp_asserts.sv
verification/tstamp_tb.sv

//--- Bender.yml
package:
  name: tstamp

sources:
  - files:
      - hdl/tstamp_pkg.sv
      - hdl/tstamp_fifo.sv
      - hdl/tstamp_reg_decode.sv
      - hdl/tstamp_capture.sv
      - hdl/tstamp_word_format.sv
      - hdl/tstamp_top.sv
  - target: test
    files:
      - verification/tstamp_asserts.sv
      - verification/tstamp_tb.sv
